/* dv/pbuf_cases.txt */
# payload_len bad_fcs accept release status_hex mac_delivery
# status bits are crc_ok, runt and giant from bit 0 upwards
60 0 1 1 01 1
1519 0 1 0 05 0
20 0 1 1 03 1
60 1 0 1 00 0

/* project.f */
verilog/pbuf_pkg.sv
verilog/dual_port_ram.sv
verilog/frame_scanner.sv
verilog/pbuf_writer.sv
verilog/pbuf_rx_top.sv
dv/clk_gen.sv
dv/pbuf_rx_tb.sv

/* Bender.yml */
package:
  name: pbuf_rx

sources:
  - verilog/pbuf_pkg.sv
  - verilog/dual_port_ram.sv
  - verilog/frame_scanner.sv
  - verilog/pbuf_writer.sv
  - verilog/pbuf_rx_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/pbuf_rx_tb.sv

/* dv/pbuf_rx_tb.sv */
// Testbench for the receive packet path.
// Reads frames from the cases file, sends them, checks the Rx MAC banks
// after each frame and the packet buffer at the end, and watches the
// badge strobe and the Gray pointer on every cycle.
`timescale 1ns/1ps

module pbuf_rx_tb;
	import pbuf_pkg::*;

	localparam int max_cases = 16;

	logic              clk;
	logic              arst_n;
	logic              rst_req;
	logic [7:0]        rx_byte;
	logic              rx_valid;
	logic [paw-1:0]    pbuf_rd_addr;
	logic [mac_aw-1:0] mac_rd_addr;
	logic              rx_mac_hbank;
	logic              rx_mac_accept;
	logic [8:0]        pbuf_rd_data;
	logic [7:0]        mac_rd_data;
	logic [1:0]        rx_mac_buf_status;
	logic [paw-1:0]    gray_state;
	logic              badge_stb;

	// One entry per line of the cases file
	int         c_pay [max_cases];
	logic       c_bad [max_cases];
	logic       c_acc [max_cases];
	logic       c_rel [max_cases];
	logic [7:0] c_st  [max_cases];
	logic       c_mac [max_cases];
	int         f_start [max_cases];
	int         f_len   [max_cases];
	int         n_cases;
	// Every byte sent on the wire, frames back to back
	logic [7:0] sent [4096];
	logic [8:0] pbuf_img [2**paw];

	int             errors;
	int             checks;
	int             cycles;
	int             cycle_limit;
	int             stb_run;
	int             stb_total;
	int             gcount;
	logic [paw-1:0] gray_prev;
	logic [paw-1:0] bin_prev;
	logic           wb;
	logic           dbank;
	int             didx;

	clk_gen u_clk (
		.clk     (clk),
		.arst_n  (arst_n),
		.rst_req (rst_req)
	);

	pbuf_rx_top dut (
		.clk               (clk),
		.arst_n            (arst_n),
		.rx_byte           (rx_byte),
		.rx_valid          (rx_valid),
		.pbuf_rd_addr      (pbuf_rd_addr),
		.mac_rd_addr       (mac_rd_addr),
		.rx_mac_hbank      (rx_mac_hbank),
		.rx_mac_accept     (rx_mac_accept),
		.pbuf_rd_data      (pbuf_rd_data),
		.mac_rd_data       (mac_rd_data),
		.rx_mac_buf_status (rx_mac_buf_status),
		.gray_state        (gray_state),
		.badge_stb         (badge_stb)
	);

	// Ethernet CRC-32, one bit at a time, LSB of each byte first
	function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int k = 0; k < 8; k++) begin
			fb = r[0] ^ b[k];
			r  = {1'b0, r[31:1]};
			if (fb)
				r = r ^ crc_poly;
		end
		return r;
	endfunction

	function automatic logic [paw-1:0] gray_to_bin(input logic [paw-1:0] g);
		logic [paw-1:0] b;
		b[paw-1] = g[paw-1];
		for (int i = paw - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("error: %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// Columns are payload, bad FCS, accept, release, status in hex, MAC delivery
	task automatic read_cases();
		int    fd;
		int    n;
		int    total;
		string line;
		fd    = $fopen("dv/pbuf_cases.txt", "r");
		total = 0;
		n_cases = 0;
		checks++;
		assert (fd != 0) else begin
			errors++;
			$display("cannot open the cases file dv/pbuf_cases.txt");
		end
		if (fd != 0) begin
			while (!$feof(fd) && n_cases < max_cases) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%d %d %d %d %h %d", c_pay[n_cases], c_bad[n_cases],
					c_acc[n_cases], c_rel[n_cases], c_st[n_cases], c_mac[n_cases]);
				if (n != 6)
					continue;
				f_start[n_cases] = total;
				f_len[n_cases]   = (c_pay[n_cases] + 4 > 2047) ? 2047 : c_pay[n_cases] + 4;
				// Size flags in the file must follow the frame limits
				check_val($sformatf("case %0d runt flag", n_cases),
					f_len[n_cases] < min_frame, c_st[n_cases][st_runt]);
				check_val($sformatf("case %0d giant flag", n_cases),
					f_len[n_cases] > max_frame, c_st[n_cases][st_giant]);
				total += c_pay[n_cases] + 4;
				n_cases++;
			end
			$fclose(fd);
		end
		checks++;
		assert (n_cases > 0) else begin
			errors++;
			$display("no frames were read from the cases file");
		end
		// Room for sending, MAC read back and the final buffer scan
		cycle_limit = 2 * total + 40 * n_cases + 2**paw + 200;
	endtask

	task automatic send_frame(input int f);
		logic [31:0] crc;
		logic [31:0] fcs;
		int          base;
		base = f_start[f];
		crc  = crc_init;
		for (int i = 0; i < c_pay[f]; i++) begin
			sent[base+i] = 8'($urandom);
			crc = crc_update(crc, sent[base+i]);
		end
		fcs = ~crc;
		if (c_bad[f])
			fcs = fcs ^ 32'h1;
		for (int k = 0; k < 4; k++)
			sent[base+c_pay[f]+k] = fcs[8*k +: 8];
		for (int i = 0; i < c_pay[f] + 4; i++) begin
			@(posedge clk);
			#1;
			rx_byte  = sent[base+i];
			rx_valid = 1'b1;
		end
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
		rx_byte  = 8'd0;
	endtask

	// The badge strobe marks the end of the writer's work on a frame
	task automatic wait_badge();
		@(negedge clk);
		while (badge_stb !== 1'b1)
			@(negedge clk);
		while (badge_stb !== 1'b0)
			@(negedge clk);
	endtask

	// Reads are pipelined, data of one address arrives with the next one
	task automatic read_mac_bank(input logic bank, input int f);
		int         n;
		int         len;
		logic [7:0] exp;
		len = f_len[f];
		n   = len + mac_data_offset;
		for (int o = 0; o <= n; o++) begin
			@(posedge clk);
			#1;
			if (o > 0) begin
				case (o - 1)
					0:       exp = {1'b1, 7'(len)};
					1:       exp = {4'd0, 4'(len >> 7)};
					2:       exp = c_st[f];
					3:       exp = 8'd0;
					default: exp = sent[f_start[f] + o - 1 - mac_data_offset];
				endcase
				check_val($sformatf("mac bank %0d frame %0d offset %0d", bank, f, o - 1),
					exp, mac_rd_data);
			end
			if (o < n)
				mac_rd_addr = {bank, 11'(o)};
		end
	endtask

	task automatic scan_pbuf();
		for (int a = 0; a <= 2**paw; a++) begin
			@(posedge clk);
			#1;
			if (a > 0)
				pbuf_img[a-1] = pbuf_rd_data;
			if (a < 2**paw)
				pbuf_rd_addr = paw'(a);
		end
	endtask

	// Two words in a row with the 9th bit set open each badge
	task automatic check_pbuf();
		int          pos;
		int          a;
		int          len;
		logic        found;
		badge_word_e w;
		pos = 0;
		for (int f = 0; f < n_cases; f++) begin
			found = 1'b0;
			a     = pos;
			len   = f_len[f];
			while (!found && a < 2**paw - 1) begin
				if (pbuf_img[a][8] === 1'b1 && pbuf_img[a+1][8] === 1'b1)
					found = 1'b1;
				else
					a++;
			end
			checks++;
			assert (found && a + badge_words + len <= 2**paw) else begin
				errors++;
				$display("frame %0d has no complete badge in the packet buffer", f);
			end
			if (found && a + badge_words + len <= 2**paw) begin
				w = bw_len_hi;
				check_val($sformatf("pbuf frame %0d %s", f, w.name()),
					{2'b11, 7'(len)}, pbuf_img[a+1]);
				w = bw_len_lo;
				check_val($sformatf("pbuf frame %0d %s", f, w.name()),
					{5'd0, 4'(len >> 7)}, pbuf_img[a+2]);
				w = bw_status;
				check_val($sformatf("pbuf frame %0d %s", f, w.name()),
					{1'b0, c_st[f]}, pbuf_img[a+3]);
				w = bw_reserved;
				check_val($sformatf("pbuf frame %0d %s", f, w.name()), 9'd0, pbuf_img[a+4]);
				for (int i = 0; i < len; i++)
					check_val($sformatf("pbuf frame %0d byte %0d", f, i),
						{1'b0, sent[f_start[f]+i]}, pbuf_img[a+badge_words+i]);
				pos = a + badge_words + len;
			end
		end
	endtask

	// Strobe run lengths and the Gray pointer, sampled away from the edges
	always @(negedge clk) begin
		if (!arst_n) begin
			stb_run = 0;
			gcount  = 0;
		end else begin
			if (badge_stb) begin
				stb_run++;
			end else if (stb_run != 0) begin
				check_val("badge strobe length", 4, stb_run);
				stb_total += stb_run;
				stb_run = 0;
			end
			// The first two samples after reset both hold zero
			if (gcount >= 2) begin
				check_val("gray single bit change", 1, $countones(gray_state ^ gray_prev));
				check_val("gray decoded step", paw'(bin_prev + 1'b1), gray_to_bin(gray_state));
			end
			gray_prev = gray_state;
			bin_prev  = gray_to_bin(gray_state);
			gcount++;
		end
	end

	// Cycle counter from time zero up to the run limit
	initial begin
		cycles = 0;
		while (cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run took longer than %0d cycles", cycle_limit);
		$display("tests failed");
		$finish;
	end

	initial begin
		rx_byte       = 8'd0;
		rx_valid      = 1'b0;
		pbuf_rd_addr  = '0;
		mac_rd_addr   = '0;
		rx_mac_hbank  = 1'b0;
		rx_mac_accept = 1'b0;
		rst_req       = 1'b0;
		errors        = 0;
		checks        = 0;
		cycle_limit   = 1000000;
		stb_total     = 0;
		void'($urandom(32'h4fd69d96));
		read_cases();
		@(posedge arst_n);
		repeat (2) @(posedge clk);
		// Model of the writer bank and of the frame the host holds
		wb   = 1'b0;
		dbank = 1'b0;
		didx = -1;
		for (int f = 0; f < n_cases; f++) begin
			if (c_rel[f]) begin
				@(posedge clk);
				#1 rx_mac_hbank = ~rx_mac_hbank;
				repeat (4) @(posedge clk);
			end
			@(posedge clk);
			#1 rx_mac_accept = c_acc[f];
			// A copy needs a free bank at the start and accept in the badge
			check_val($sformatf("case %0d bank rule", f),
				(wb != rx_mac_hbank) && c_acc[f], c_mac[f]);
			send_frame(f);
			wait_badge();
			repeat (3) @(negedge clk);
			if (c_mac[f]) begin
				dbank = wb;
				wb    = ~wb;
				didx  = f;
			end
			check_val($sformatf("frame %0d bank status", f), {rx_mac_hbank, wb},
				rx_mac_buf_status);
			if (didx >= 0)
				read_mac_bank(dbank, didx);
		end
		// Reset stops the writer so the buffer holds still for the scan
		@(posedge clk);
		#1 rst_req = 1'b1;
		repeat (2) @(posedge clk);
		scan_pbuf();
		check_pbuf();
		check_val("badge strobe total", 4 * n_cases, stb_total);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* dv/clk_gen.sv */
// Clock and reset source for the testbench.
// 8 ns clock, reset held low for the first 8 cycles.
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic arst_n,
	input  logic rst_req
);

	logic rst_done;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Release comes just after an edge so it never races the first one
	initial begin
		rst_done = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_done = 1'b1;
	end

	// The testbench can pull reset again to stop the packet buffer writes
	assign arst_n = rst_done & ~rst_req;

endmodule

/* verilog/pbuf_rx_top.sv */
// Top level of the receive packet path.
// Frame scanner feeding the packet buffer writer, with the packet
// buffer RAM and the double-banked Rx MAC RAM behind it.
`timescale 1ns/1ps

module pbuf_rx_top (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [7:0]                  rx_byte,
	input  logic                        rx_valid,
	input  logic [pbuf_pkg::paw-1:0]    pbuf_rd_addr,
	input  logic [pbuf_pkg::mac_aw-1:0] mac_rd_addr,
	input  logic                        rx_mac_hbank,
	input  logic                        rx_mac_accept,
	output logic [8:0]                  pbuf_rd_data,
	output logic [7:0]                  mac_rd_data,
	output logic [1:0]                  rx_mac_buf_status,
	output logic [pbuf_pkg::paw-1:0]    gray_state,
	output logic                        badge_stb
);
	import pbuf_pkg::*;

	// Scanner outputs
	logic [7:0]        data_in;
	logic              data_s;
	logic              data_f;
	logic [len_w-1:0]  pack_len;
	logic [7:0]        status_vec;
	logic              status_valid;
	// Writer outputs towards the two memories
	logic [8:0]        mem_d;
	logic [paw-1:0]    mem_a;
	logic [7:0]        rx_mac_d;
	logic [mac_aw-1:0] rx_mac_a;
	logic              rx_mac_wen;

	frame_scanner u_scanner (
		.clk          (clk),
		.arst_n       (arst_n),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid),
		.data_in      (data_in),
		.data_s       (data_s),
		.data_f       (data_f),
		.pack_len     (pack_len),
		.status_vec   (status_vec),
		.status_valid (status_valid)
	);

	pbuf_writer u_writer (
		.clk               (clk),
		.arst_n            (arst_n),
		.data_in           (data_in),
		.data_s            (data_s),
		.data_f            (data_f),
		.pack_len          (pack_len),
		.status_vec        (status_vec),
		.status_valid      (status_valid),
		.rx_mac_hbank      (rx_mac_hbank),
		.rx_mac_accept     (rx_mac_accept),
		.mem_d             (mem_d),
		.mem_a             (mem_a),
		.rx_mac_d          (rx_mac_d),
		.rx_mac_a          (rx_mac_a),
		.rx_mac_wen        (rx_mac_wen),
		.rx_mac_buf_status (rx_mac_buf_status),
		.gray_state        (gray_state),
		.badge_stb         (badge_stb)
	);

	// Packet buffer is written on every cycle once out of reset
	dual_port_ram #(.data_width(9), .addr_width(paw)) u_pbuf_ram (
		.clk   (clk),
		.wen   (arst_n),
		.waddr (mem_a),
		.wdata (mem_d),
		.raddr (pbuf_rd_addr),
		.rdata (pbuf_rd_data)
	);

	// Two banks of 2048 bytes, the writer picks the bank with the top bit
	dual_port_ram #(.data_width(8), .addr_width(mac_aw)) u_mac_ram (
		.clk   (clk),
		.wen   (rx_mac_wen),
		.waddr (rx_mac_a),
		.wdata (rx_mac_d),
		.raddr (mac_rd_addr),
		.rdata (mac_rd_data)
	);

endmodule

/* verilog/pbuf_writer.sv */
// Packet buffer writer.
// Builds the badge-plus-data word stream for the packet buffer, copies
// accepted frames into the double-banked Rx MAC memory under the host
// bank handshake, and exports the write pointer in Gray code.
`timescale 1ns/1ps

module pbuf_writer (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [7:0]                  data_in,
	input  logic                        data_s,
	input  logic                        data_f,
	input  logic [pbuf_pkg::len_w-1:0]  pack_len,
	input  logic [7:0]                  status_vec,
	input  logic                        status_valid,
	input  logic                        rx_mac_hbank,
	input  logic                        rx_mac_accept,
	output logic [8:0]                  mem_d,
	output logic [pbuf_pkg::paw-1:0]    mem_a,
	output logic [7:0]                  rx_mac_d,
	output logic [pbuf_pkg::mac_aw-1:0] rx_mac_a,
	output logic                        rx_mac_wen,
	output logic [1:0]                  rx_mac_buf_status,
	output logic [pbuf_pkg::paw-1:0]    gray_state,
	output logic                        badge_stb
);
	import pbuf_pkg::*;

	badge_word_e       badge_cnt;
	logic              not_head;
	logic              data_s_d;
	logic              trig;
	logic [7:0]        status_r;
	logic [paw-1:0]    fp;
	logic [paw-1:0]    fpp;
	logic [paw-1:0]    origin;
	logic [8:0]        pxd;
	logic              hbank_meta;
	logic              hbank_sync;
	logic              mac_bank;
	logic              bank_ready;
	logic [mac_aw-2:0] mac_a0;
	logic              mac_save;
	logic              mac_stopping;
	logic              mac_queue;

	// Counter parks at bw_pass and data then flows straight through
	assign not_head = (badge_cnt == bw_pass);
	// First byte of a frame reaches us
	assign trig = data_s & ~data_s_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status_r <= '0;
		end else if (status_valid) begin
			status_r <= status_vec;
		end
	end

	// Packet buffer stream. Data and idle words go five ahead of the pointer,
	// leaving room for the badge which is filled in once the frame is over
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			badge_cnt <= bw_pass;
			data_s_d  <= 1'b0;
			fp        <= '0;
			fpp       <= '0;
			origin    <= '0;
			pxd       <= '0;
			badge_stb <= 1'b0;
		end else begin
			data_s_d <= data_s;
			if (data_f)
				badge_cnt <= bw_dummy;
			else if (!not_head)
				badge_cnt <= badge_word_e'(badge_cnt + 3'd1);
			// Remember where this frame's badge goes
			if (trig)
				origin <= fp;
			// Only the first two badge words carry the 9th bit
			case (badge_cnt)
				bw_dummy:    pxd <= {1'b1, 8'd0};
				bw_len_hi:   pxd <= {1'b1, 1'b1, pack_len[6:0]};
				bw_len_lo:   pxd <= {5'd0, pack_len[len_w-1:7]};
				bw_status:   pxd <= {1'b0, status_r};
				bw_reserved: pxd <= 9'd0;
				default:     pxd <= {1'b0, data_in};
			endcase
			fp <= fp + 1'b1;
			// Rewind to the origin while the badge is being written
			fpp <= not_head ? fp + paw'(badge_words) : origin + paw'(badge_cnt);
			badge_stb <= !not_head && (badge_cnt != bw_dummy);
		end
	end

	assign mem_a = fpp;
	assign mem_d = pxd;

	// Two flops bring the host bank toggle into our clock domain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hbank_meta <= 1'b0;
			hbank_sync <= 1'b0;
		end else begin
			hbank_meta <= rx_mac_hbank;
			hbank_sync <= hbank_meta;
		end
	end

	// The host holds the bank it names, so we may only write the other one
	assign bank_ready = (mac_bank != hbank_sync);

	// MAC copy. Data starts at offset 4, badge bytes 2 to 5 then land at 0 to 3
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mac_a0       <= '0;
			mac_bank     <= 1'b0;
			mac_save     <= 1'b0;
			mac_stopping <= 1'b0;
			mac_queue    <= 1'b0;
		end else begin
			if (trig && bank_ready)
				mac_save <= 1'b1;
			if (trig)
				mac_a0 <= (mac_aw-1)'(mac_data_offset);
			else if (badge_cnt == bw_len_hi)
				mac_a0 <= '0;
			else
				mac_a0 <= mac_a0 + 1'b1;
			// Reserved word is on its way, stop after it has been written
			mac_stopping <= (badge_cnt == bw_reserved);
			if (mac_stopping)
				mac_save <= 1'b0;
			// Frame is committed to the host once accept is seen here
			if (badge_cnt == bw_len_hi && mac_save && rx_mac_accept)
				mac_queue <= 1'b1;
			if (mac_stopping && mac_queue) begin
				mac_bank  <= ~mac_bank;
				mac_queue <= 1'b0;
			end
		end
	end

	assign rx_mac_d          = pxd[7:0];
	assign rx_mac_a          = {mac_bank, mac_a0};
	assign rx_mac_wen        = mac_save;
	assign rx_mac_buf_status = {hbank_sync, mac_bank};

	// Gray code lets a reader in another domain sample the pointer safely
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			gray_state <= '0;
		else
			gray_state <= fp ^ (fp >> 1);
	end

endmodule

/* verilog/frame_scanner.sv */
// Frame scanner for the receive byte stream.
// Delays the stream by one cycle, counts the frame length, runs CRC-32
// and checks the size limits, then pulses the end strobe with the status.
`timescale 1ns/1ps

module frame_scanner (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [7:0]                 rx_byte,
	input  logic                       rx_valid,
	output logic [7:0]                 data_in,
	output logic                       data_s,
	output logic                       data_f,
	output logic [pbuf_pkg::len_w-1:0] pack_len,
	output logic [7:0]                 status_vec,
	output logic                       status_valid
);
	import pbuf_pkg::*;

	logic             data_s_d;
	logic             first_byte;
	logic             frame_end;
	logic [31:0]      crc;
	logic [len_w-1:0] len_cnt;
	logic [7:0]       status_next;

	// One byte of the reflected CRC-32, LSB first as on the wire
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c ^ {24'd0, b};
		for (int i = 0; i < 8; i++) begin
			r = r[0] ? ((r >> 1) ^ crc_poly) : (r >> 1);
		end
		return r;
	endfunction

	// data_s still holds the previous rx_valid, so this marks byte zero
	assign first_byte = rx_valid & ~data_s;
	// Falling edge of the delayed valid, one cycle before data_f
	assign frame_end = data_s_d & ~data_s;

	// The CRC covers the FCS too, so a good frame leaves the fixed residue
	always_comb begin
		status_next = '0;
		status_next[st_crc_ok] = (crc == crc_residue);
		status_next[st_runt]   = (len_cnt < min_frame);
		status_next[st_giant]  = (len_cnt > max_frame);
	end

	// Byte delay line towards the writer
	always_ff @(posedge clk) begin
		data_in <= rx_byte;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_s     <= 1'b0;
			data_s_d   <= 1'b0;
			data_f     <= 1'b0;
			crc        <= crc_init;
			len_cnt    <= '0;
			status_vec <= '0;
		end else begin
			data_s   <= rx_valid;
			data_s_d <= data_s;
			// Pulse lands in the cycle after data_s has gone low
			data_f   <= frame_end;
			if (rx_valid) begin
				if (first_byte) begin
					len_cnt <= len_w'(1);
					crc     <= crc_byte(crc_init, rx_byte);
				end else begin
					// Length sticks at all ones for oversized frames
					if (len_cnt != '1)
						len_cnt <= len_cnt + 1'b1;
					crc <= crc_byte(crc, rx_byte);
				end
			end
			// Status is captured together with the end pulse
			if (frame_end)
				status_vec <= status_next;
		end
	end

	// Length holds after the frame until the next first byte
	assign pack_len     = len_cnt;
	assign status_valid = data_f;

endmodule

/* verilog/dual_port_ram.sv */
// Simple dual-port RAM.
// One synchronous write port and one registered read port.
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int data_width = 8,
	parameter int addr_width = 10
) (
	input  logic                  clk,
	input  logic                  wen,
	input  logic [addr_width-1:0] waddr,
	input  logic [data_width-1:0] wdata,
	input  logic [addr_width-1:0] raddr,
	output logic [data_width-1:0] rdata
);

	// Contents are left as they come up, nothing clears them
	logic [data_width-1:0] mem [2**addr_width];

	always_ff @(posedge clk) begin
		if (wen)
			mem[waddr] <= wdata;
	end

	// Read data shows up one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

/* verilog/pbuf_pkg.sv */
// Shared constants for the receive packet path.
// Address widths, badge layout and badge-word enum, frame limits,
// status bit positions and CRC-32 constants.
package pbuf_pkg;

	// Packet buffer holds 2048 words of 9 bits
	localparam int paw = 11;
	// Rx MAC memory, top address bit selects the bank
	localparam int mac_aw = 12;
	// Frame length counter width, saturates at 2047
	localparam int len_w = 11;

	// Badge occupies five words in front of the frame data
	localparam int badge_words = 5;
	// First data byte inside a MAC bank, after length and status bytes
	localparam int mac_data_offset = 4;

	// Writer badge counter, bw_pass means data flows straight through
	typedef enum logic [2:0] {
		bw_dummy    = 3'd0,
		bw_len_hi   = 3'd1,
		bw_len_lo   = 3'd2,
		bw_status   = 3'd3,
		bw_reserved = 3'd4,
		bw_pass     = 3'd5
	} badge_word_e;

	// Frame size limits in bytes, FCS included
	localparam int min_frame = 64;
	localparam int max_frame = 1522;

	// Bit positions in the status byte, all other bits stay zero
	localparam int st_crc_ok = 0;
	localparam int st_runt   = 1;
	localparam int st_giant  = 2;

	// Reflected CRC-32 as used by Ethernet
	localparam logic [31:0] crc_poly    = 32'hEDB88320;
	localparam logic [31:0] crc_init    = 32'hFFFFFFFF;
	// Register value after a frame with a correct FCS has been shifted in
	localparam logic [31:0] crc_residue = 32'hDEBB20E3;

endpackage
